// ==== verilog.f ====
verilog/spidergon_pkg.sv
verilog/flit_buffer.sv
verilog/spidergon_route.sv
verilog/output_arbiter.sv
verilog/spidergon_node.sv
verilog/spidergon_top.sv
verif/spidergon_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spidergon testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module spidergon_tb -f verilog.f -o spidergon_sim
./obj_dir/spidergon_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	exit 1
fi
exit 0

// ==== verif/spidergon_tb.sv ====
// testbench for the eight-node spidergon network with directed and random traffic and a scoreboard
`timescale 1ns/100ps
`default_nettype none

module spidergon_tb;

	localparam int wait_limit = 2000;
	localparam int max_in_flight = 4;

	logic clk;
	logic reset;
	spidergon_pkg::flit_t [spidergon_pkg::num_nodes-1:0] inject;
	logic [spidergon_pkg::num_nodes-1:0] inject_valid;
	logic [spidergon_pkg::num_nodes-1:0] inject_ready;
	spidergon_pkg::flit_t [spidergon_pkg::num_nodes-1:0] eject;
	logic [spidergon_pkg::num_nodes-1:0] eject_valid;
	logic [spidergon_pkg::num_nodes-1:0] eject_ready;

	// flits inside the network in the order they were sent
	spidergon_pkg::flit_t pending [$];
	string test_name;
	int error_count;
	int errors_at_start;
	int test_count;
	int delivered;
	bit timed_out;
	bit stall_mode;
	logic [15:0] traffic_lfsr;
	logic [15:0] stall_lfsr;

	spidergon_top DUT (
		.clk(clk),
		.reset(reset),
		.inject(inject),
		.inject_valid(inject_valid),
		.inject_ready(inject_ready),
		.eject(eject),
		.eject_valid(eject_valid),
		.eject_ready(eject_ready)
	);

	always #4 clk = ~clk;

	// galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	task automatic draw_bits(inout logic [15:0] state, input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			state = lfsr_step(state);
			value = (value << 1) | int'(state[0]);
		end
	endtask

	// a single-flit packet always leaves the network at its destination
	function automatic spidergon_pkg::node_id_t expected_eject_node(input spidergon_pkg::flit_t f);
		return f.dest;
	endfunction

	function automatic spidergon_pkg::flit_t make_flit(input int src, input int dest, input int data);
		spidergon_pkg::flit_t f;
		f.dest = spidergon_pkg::node_id_t'(dest);
		f.src = spidergon_pkg::node_id_t'(src);
		f.payload = spidergon_pkg::payload_t'(data);
		return f;
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		test_count++;
	endtask

	task automatic end_test();
		$display("%s: done with %0d errors", test_name, error_count - errors_at_start);
	endtask

	task automatic report_timeout(input string what);
		$display("%s: timed out after %0d cycles while %s", test_name, wait_limit, what);
		error_count++;
		timed_out = 1'b1;
	endtask

	// entered and left just after a falling edge
	task automatic send_packet(input spidergon_pkg::flit_t f);
		int cycles;
		if (timed_out)
			return;
		inject[f.src] = f;
		inject_valid[f.src] = 1'b1;
		cycles = 0;
		while (!inject_ready[f.src] && cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!inject_ready[f.src])
			report_timeout("waiting for inject_ready");
		else
			pending.push_back(f);
		@(negedge clk);
		inject_valid[f.src] = 1'b0;
	endtask

	task automatic wait_for_room();
		int cycles;
		cycles = 0;
		while (!timed_out && pending.size() >= max_in_flight && cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && pending.size() >= max_in_flight)
			report_timeout("waiting for a free slot in flight");
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (!timed_out && pending.size() != 0 && cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && pending.size() != 0)
			report_timeout($sformatf("%0d packets were still undelivered", pending.size()));
	endtask

	// random eject stalls keep each port ready three cycles in four
	always @(negedge clk)
	begin
		int r;
		if (stall_mode)
		begin
			for (int n = 0; n < spidergon_pkg::num_nodes; n++)
			begin
				draw_bits(stall_lfsr, 2, r);
				eject_ready[n] = (r != 0);
			end
		end
	end

	// scoreboard matches each ejected flit to the oldest one sent on its pair
	always @(posedge clk)
	begin
		int idx;
		spidergon_pkg::flit_t got;
		spidergon_pkg::flit_t want;
		if (!reset)
		begin
			for (int n = 0; n < spidergon_pkg::num_nodes; n++)
			begin
				if (eject_valid[n] && eject_ready[n])
				begin
					got = eject[n];
					idx = -1;
					for (int k = 0; k < pending.size(); k++)
					begin
						if (idx < 0 && pending[k].src == got.src &&
								int'(expected_eject_node(pending[k])) == n)
							idx = k;
					end
					if (idx < 0)
					begin
						$display("%s: node %0d ejected flit %h that was never sent to it",
							test_name, n, got);
						error_count++;
					end
					else
					begin
						want = pending[idx];
						pending.delete(idx);
						delivered++;
						if (got !== want)
						begin
							$display("[ERROR] %s: node %0d expected %h actual %h",
								test_name, n, want, got);
							error_count++;
						end
					end
				end
			end
		end
	end

	initial
	begin
		int r;
		int s;
		int d;
		int cycles;
		spidergon_pkg::flit_t first;
		spidergon_pkg::flit_t held;
		clk = 1'b0;
		reset = 1'b1;
		inject = '0;
		inject_valid = '0;
		eject_ready = '1;
		error_count = 0;
		test_count = 0;
		delivered = 0;
		timed_out = 1'b0;
		stall_mode = 1'b0;
		traffic_lfsr = 16'd25;
		stall_lfsr = 16'd25;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		start_test("reset_state");
		if (eject_valid !== '0)
		begin
			$display("[ERROR] %s: eject_valid expected %h actual %h", test_name, 8'h00, eject_valid);
			error_count++;
		end
		if (inject_ready !== '1)
		begin
			$display("[ERROR] %s: inject_ready expected %h actual %h", test_name, 8'hff, inject_ready);
			error_count++;
		end
		end_test();

		// one packet at a time, so an eject at any other node has no match
		start_test("point_to_point");
		@(negedge clk);
		for (int i = 0; i < spidergon_pkg::num_nodes * spidergon_pkg::num_nodes; i++)
		begin
			draw_bits(traffic_lfsr, spidergon_pkg::payload_width, r);
			send_packet(make_flit(i / spidergon_pkg::num_nodes, i % spidergon_pkg::num_nodes, r));
			wait_drained();
		end
		end_test();

		start_test("self_addressed");
		for (int n = 0; n < spidergon_pkg::num_nodes; n++)
		begin
			send_packet(make_flit(n, n, 'h2a5 ^ (n * 37)));
			wait_drained();
		end
		end_test();

		start_test("random_traffic");
		stall_mode = 1'b1;
		for (int k = 0; k < 200; k++)
		begin
			wait_for_room();
			draw_bits(traffic_lfsr, spidergon_pkg::node_id_width, s);
			draw_bits(traffic_lfsr, spidergon_pkg::node_id_width, d);
			draw_bits(traffic_lfsr, spidergon_pkg::payload_width, r);
			send_packet(make_flit(s, d, r));
		end
		wait_drained();
		stall_mode = 1'b0;
		eject_ready = '1;
		end_test();

		start_test("backpressure_hold");
		eject_ready[5] = 1'b0;
		first = make_flit(1, 5, 'h155);
		send_packet(first);
		send_packet(make_flit(1, 5, 'h0aa));
		cycles = 0;
		while (!timed_out && !eject_valid[5] && cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!timed_out && !eject_valid[5])
			report_timeout("waiting for eject_valid at node 5");
		if (!timed_out)
		begin
			held = eject[5];
			if (held !== first)
			begin
				$display("[ERROR] %s: held flit expected %h actual %h", test_name, first, held);
				error_count++;
			end
			// the stalled flit must stay put
			repeat (16)
			begin
				@(negedge clk);
				if (eject_valid[5] !== 1'b1 || eject[5] !== held)
				begin
					$display("[ERROR] %s: stalled eject expected 1 %h actual %b %h",
						test_name, held, eject_valid[5], eject[5]);
					error_count++;
				end
			end
			eject_ready[5] = 1'b1;
			wait_drained();
		end
		end_test();

		$display("tests run %0d, packets delivered %0d, errors %0d",
			test_count, delivered, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/spidergon_top.sv ====
// eight-node spidergon network with ring and across links between the routers
`timescale 1ns/100ps
`default_nettype none

module spidergon_top (
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t [spidergon_pkg::num_nodes-1:0] inject,
	input logic [spidergon_pkg::num_nodes-1:0] inject_valid,
	output logic [spidergon_pkg::num_nodes-1:0] inject_ready,
	output spidergon_pkg::flit_t [spidergon_pkg::num_nodes-1:0] eject,
	output logic [spidergon_pkg::num_nodes-1:0] eject_valid,
	input logic [spidergon_pkg::num_nodes-1:0] eject_ready
);

	spidergon_pkg::link_t [spidergon_pkg::num_ports-2:0] node_in [spidergon_pkg::num_nodes];
	spidergon_pkg::link_t [spidergon_pkg::num_ports-2:0] node_out [spidergon_pkg::num_nodes];
	logic [spidergon_pkg::num_ports-2:0] node_in_ready [spidergon_pkg::num_nodes];
	logic [spidergon_pkg::num_ports-2:0] node_out_ready [spidergon_pkg::num_nodes];
	spidergon_pkg::link_t node_eject [spidergon_pkg::num_nodes];

	for (genvar n = 0; n < spidergon_pkg::num_nodes; n++)
	begin : g_node
		// anticlockwise side talks to the previous node's clockwise port
		assign node_in[n][spidergon_pkg::dir_anticlockwise] =
			node_out[(n + spidergon_pkg::num_nodes - 1) % spidergon_pkg::num_nodes]
				[spidergon_pkg::dir_clockwise];
		assign node_out_ready[n][spidergon_pkg::dir_anticlockwise] =
			node_in_ready[(n + spidergon_pkg::num_nodes - 1) % spidergon_pkg::num_nodes]
				[spidergon_pkg::dir_clockwise];

		// clockwise side talks to the next node's anticlockwise port
		assign node_in[n][spidergon_pkg::dir_clockwise] =
			node_out[(n + 1) % spidergon_pkg::num_nodes][spidergon_pkg::dir_anticlockwise];
		assign node_out_ready[n][spidergon_pkg::dir_clockwise] =
			node_in_ready[(n + 1) % spidergon_pkg::num_nodes][spidergon_pkg::dir_anticlockwise];

		// across links pair each node with the one opposite
		assign node_in[n][spidergon_pkg::dir_across] =
			node_out[(n + spidergon_pkg::half_nodes) % spidergon_pkg::num_nodes]
				[spidergon_pkg::dir_across];
		assign node_out_ready[n][spidergon_pkg::dir_across] =
			node_in_ready[(n + spidergon_pkg::half_nodes) % spidergon_pkg::num_nodes]
				[spidergon_pkg::dir_across];

		assign eject[n] = node_eject[n].flit;
		assign eject_valid[n] = node_eject[n].valid;

		spidergon_node #(
			.NODE_ID(n)
		) u_node (
			.clk(clk),
			.reset(reset),
			.link_in(node_in[n]),
			.link_in_ready(node_in_ready[n]),
			.link_out(node_out[n]),
			.link_out_ready(node_out_ready[n]),
			.inject(inject[n]),
			.inject_valid(inject_valid[n]),
			.inject_ready(inject_ready[n]),
			.eject(node_eject[n]),
			.eject_ready(eject_ready[n])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/spidergon_node.sv ====
// one spidergon router with buffered inputs, route units and arbitrated output registers
`timescale 1ns/100ps
`default_nettype none

module spidergon_node #(
	parameter int NODE_ID = 0
) (
	input logic clk,
	input logic reset,
	input spidergon_pkg::link_t [spidergon_pkg::num_ports-2:0] link_in,
	output logic [spidergon_pkg::num_ports-2:0] link_in_ready,
	output spidergon_pkg::link_t [spidergon_pkg::num_ports-2:0] link_out,
	input logic [spidergon_pkg::num_ports-2:0] link_out_ready,
	input spidergon_pkg::flit_t inject,
	input logic inject_valid,
	output logic inject_ready,
	output spidergon_pkg::link_t eject,
	input logic eject_ready
);

	// every side indexed by direction with local in the top slot
	spidergon_pkg::link_t [spidergon_pkg::num_ports-1:0] in_link;
	spidergon_pkg::link_t [spidergon_pkg::num_ports-1:0] out_link;
	logic [spidergon_pkg::num_ports-1:0] out_ready;

	logic [spidergon_pkg::num_ports-1:0] buf_push;
	logic [spidergon_pkg::num_ports-1:0] buf_ready;
	logic [spidergon_pkg::num_ports-1:0] buf_valid;
	logic [spidergon_pkg::num_ports-1:0] buf_pop;
	spidergon_pkg::flit_t [spidergon_pkg::num_ports-1:0] buf_head;
	spidergon_pkg::port_dir_e route_dir [spidergon_pkg::num_ports];

	// req[o][p] and grant[o][p] relate output o to input buffer p
	logic [spidergon_pkg::num_ports-1:0] req [spidergon_pkg::num_ports];
	logic [spidergon_pkg::num_ports-1:0] grant [spidergon_pkg::num_ports];

	assign in_link = {inject_valid, inject, link_in};
	assign out_ready = {eject_ready, link_out_ready};

	assign link_in_ready = buf_ready[spidergon_pkg::num_ports-2:0];
	assign inject_ready = buf_ready[spidergon_pkg::dir_local];
	assign link_out = out_link[spidergon_pkg::num_ports-2:0];
	assign eject = out_link[spidergon_pkg::dir_local];

	for (genvar p = 0; p < spidergon_pkg::num_ports; p++)
	begin : g_input
		// a flit transfers when valid and ready are both high
		assign buf_push[p] = in_link[p].valid && buf_ready[p];

		flit_buffer u_buffer (
			.clk(clk),
			.reset(reset),
			.in_flit(in_link[p].flit),
			.push(buf_push[p]),
			.ready(buf_ready[p]),
			.head(buf_head[p]),
			.head_valid(buf_valid[p]),
			.pop(buf_pop[p])
		);

		spidergon_route #(
			.NODE_ID(NODE_ID)
		) u_route (
			.flit(buf_head[p]),
			.dir(route_dir[p])
		);
	end

	// each head flit requests the output its route unit chose
	always_comb
	begin
		for (int o = 0; o < spidergon_pkg::num_ports; o++)
		begin
			for (int p = 0; p < spidergon_pkg::num_ports; p++)
				req[o][p] = buf_valid[p] && (route_dir[p] == 2'(o));
		end
	end

	always_comb
	begin
		buf_pop = '0;
		for (int o = 0; o < spidergon_pkg::num_ports; o++)
			buf_pop = buf_pop | grant[o];
	end

	for (genvar o = 0; o < spidergon_pkg::num_ports; o++)
	begin : g_output
		output_arbiter u_arbiter (
			.clk(clk),
			.reset(reset),
			.req(req[o]),
			.cand(buf_head),
			.grant(grant[o]),
			.out(out_link[o]),
			.out_ready(out_ready[o])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/output_arbiter.sv ====
// round-robin arbiter for one router output together with its holding register
`timescale 1ns/100ps
`default_nettype none

module output_arbiter (
	input logic clk,
	input logic reset,
	input logic [spidergon_pkg::num_ports-1:0] req,
	input spidergon_pkg::flit_t [spidergon_pkg::num_ports-1:0] cand,
	output logic [spidergon_pkg::num_ports-1:0] grant,
	output spidergon_pkg::link_t out,
	input logic out_ready
);

	spidergon_pkg::port_dir_e prio;
	spidergon_pkg::port_dir_e sel;
	logic found;
	logic can_load;
	logic out_valid;
	spidergon_pkg::flit_t out_flit;

	// register is free if empty or if its flit leaves this cycle
	assign can_load = !out_valid || out_ready;

	// first requester at or after the priority pointer, wrapping round
	always_comb
	begin
		spidergon_pkg::port_dir_e idx;
		found = 1'b0;
		sel = prio;
		for (int i = 0; i < spidergon_pkg::num_ports; i++)
		begin
			idx = spidergon_pkg::port_dir_e'(prio + 2'(i));
			if (!found && req[idx])
			begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	always_comb
	begin
		grant = '0;
		if (found && can_load)
			grant[sel] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			prio <= spidergon_pkg::dir_anticlockwise;
		end
		else if (|grant)
		begin
			out_valid <= 1'b1;
			// the winner drops to lowest priority next time
			prio <= spidergon_pkg::port_dir_e'(sel + 2'd1);
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (|grant)
			out_flit <= cand[sel];
	end

	assign out.valid = out_valid;
	assign out.flit = out_flit;

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("output_arbiter granted more than one input");

	// a stalled flit must wait unchanged for the receiver
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		out.valid && !out_ready |=> out.valid && $stable(out.flit))
		else $error("output_arbiter changed a stalled flit");

endmodule

`default_nettype wire

// ==== verilog/spidergon_route.sv ====
// picks the output direction of a flit from its destination and this node's number
`timescale 1ns/100ps
`default_nettype none

module spidergon_route #(
	parameter int NODE_ID = 0
) (
	input spidergon_pkg::flit_t flit,
	output spidergon_pkg::port_dir_e dir
);

	spidergon_pkg::node_id_t offset;

	// the subtraction wraps at the ring size, giving the clockwise distance
	assign offset = flit.dest - spidergon_pkg::node_id_t'(NODE_ID);

	// shortest path
	// after an across hop the remaining offset is 7, 0 or 1, so across is never taken twice
	always_comb
	begin
		if (offset == '0)
			dir = spidergon_pkg::dir_local;
		else if (offset <= spidergon_pkg::node_id_t'(spidergon_pkg::quarter_nodes))
			dir = spidergon_pkg::dir_clockwise;
		else if (offset >= spidergon_pkg::node_id_t'(spidergon_pkg::num_nodes -
				spidergon_pkg::quarter_nodes))
			dir = spidergon_pkg::dir_anticlockwise;
		else
			dir = spidergon_pkg::dir_across;
	end

endmodule

`default_nettype wire

// ==== verilog/flit_buffer.sv ====
// two-entry FIFO holding the flits that arrive on one router input
`timescale 1ns/100ps
`default_nettype none

module flit_buffer (
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t in_flit,
	input logic push,
	output logic ready,
	output spidergon_pkg::flit_t head,
	output logic head_valid,
	input logic pop
);

	spidergon_pkg::flit_t mem [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;

	// ready only looks at the fill level, never at the sender's valid
	assign ready = (count != 2'd2);
	assign head_valid = (count != 2'd0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// push and pop together leave the count unchanged
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	push_has_room: assert property (@(posedge clk) disable iff (reset) push |-> ready)
		else $error("flit_buffer push while full");

	pop_has_data: assert property (@(posedge clk) disable iff (reset) pop |-> head_valid)
		else $error("flit_buffer pop while empty");

endmodule

`default_nettype wire

// ==== verilog/spidergon_pkg.sv ====
// spidergon network package with ring constants, flit and link formats and port directions
`default_nettype none

package spidergon_pkg;

	// ring geometry
	localparam int num_nodes = 8;

	// the node opposite sits half way round the ring
	localparam int half_nodes = num_nodes / 2;

	// offsets up to this value go clockwise, their mirror images go anticlockwise
	localparam int quarter_nodes = num_nodes / 4;

	localparam int node_id_width = $clog2(num_nodes);
	localparam int payload_width = 10;

	// anticlockwise, clockwise, across and local
	localparam int num_ports = 4;

	// node number on the ring
	typedef logic [node_id_width-1:0] node_id_t;

	// user data carried by a packet
	typedef logic [payload_width-1:0] payload_t;

	// a whole packet fits in one flit
	typedef struct packed {
		node_id_t dest;
		node_id_t src;
		payload_t payload;
	} flit_t;

	// what a sender drives towards its neighbour, ready travels back separately
	typedef struct packed {
		logic valid;
		flit_t flit;
	} link_t;

	// indexes inputs, outputs and route results
	// local is inject on the input side and eject on the output side
	typedef enum logic [1:0] {
		dir_anticlockwise = 2'd0,
		dir_clockwise = 2'd1,
		dir_across = 2'd2,
		dir_local = 2'd3
	} port_dir_e;

endpackage

`default_nettype wire
